/* design/noc_flit_pkg.sv */
// ==========================================================================
// Single-flit packets only; the destination travels in every flit
// Coordinates are 4 bits, so the mesh is at most 16 x 16 nodes
// ==========================================================================
`default_nettype none

package noc_flit_pkg;

  // Bits per mesh coordinate
  localparam int COORD_W = 4;

  // Bits of user data per flit
  localparam int PAYLOAD_W = 8;

  // Row or column index of a node
  typedef logic [COORD_W-1:0] coord_t;

  // User data carried by a flit
  typedef logic [PAYLOAD_W-1:0] payload_t;

  // Flit layout from MSB down to LSB
  // 16 bits in all
  typedef struct packed {
    coord_t   dst_y;    // Destination row
    coord_t   dst_x;    // Destination column
    payload_t payload;  // Data
  } flit_t;

endpackage

`default_nettype wire

/* design/noc_port_pkg.sv */
// ==========================================================================
// Port order is fixed as N, E, S, W, L with indices 0 to 4
// ==========================================================================
`default_nettype none

package noc_port_pkg;

  import noc_flit_pkg::*;

  // Ports of an inner mesh node
  localparam int NUM_PORTS = 5;

  // Index of one router port
  typedef logic [2:0] port_idx_t;

  // Port indices
  localparam port_idx_t PORT_N = 3'd0;
  localparam port_idx_t PORT_E = 3'd1;
  localparam port_idx_t PORT_S = 3'd2;
  localparam port_idx_t PORT_W = 3'd3;
  localparam port_idx_t PORT_L = 3'd4;

  // One bit per port
  typedef logic [NUM_PORTS-1:0] port_vec_t;

  // One flit per port, 80 bits
  typedef flit_t [NUM_PORTS-1:0] flit_bus_t;

  // Indexed by output port
  // Each entry is a one-hot mask of the granted input
  typedef port_vec_t [NUM_PORTS-1:0] grant_mat_t;

endpackage

`default_nettype wire

/* design/input_buffer.sv */
// ==========================================================================
// BUF_DEPTH must be a power of two and at least 2
// A write into a full FIFO is dropped without any flag
// ==========================================================================
`timescale 1ns/100ps
`default_nettype none

module input_buffer #(
  parameter int BUF_DEPTH = 4
) (
  input  wire logic                 clk,
  input  wire logic                 arst_n_i,
  input  wire logic                 wr_i,
  input  wire logic                 rd_i,
  input  wire noc_flit_pkg::flit_t  wr_flit_i,
  output noc_flit_pkg::flit_t       head_flit_o,
  output logic                      empty_o
);

  import noc_flit_pkg::*;

  // Address bits of the storage array
  localparam int ADDR_W = $clog2(BUF_DEPTH);

  // Pointer with one extra wrap bit
  typedef logic [ADDR_W:0] ptr_t;

  // Flit storage
  flit_t mem [BUF_DEPTH];

  ptr_t wr_ptr_q;
  ptr_t rd_ptr_q;
  logic full;
  logic empty;
  logic wr_en;
  logic rd_en;

  // Same address but wrap bits differ means full
  assign full  = (wr_ptr_q[ADDR_W] != rd_ptr_q[ADDR_W]) &&
                 (wr_ptr_q[ADDR_W-1:0] == rd_ptr_q[ADDR_W-1:0]);
  assign empty = (wr_ptr_q == rd_ptr_q);

  // Ignore writes when full and reads when empty
  assign wr_en = wr_i && !full;
  assign rd_en = rd_i && !empty;

  // Pointer update
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= wr_ptr_q + ptr_t'(1);
      end
      if (rd_en) begin
        rd_ptr_q <= rd_ptr_q + ptr_t'(1);
      end
    end
  end

  // Storage write
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr_q[ADDR_W-1:0]] <= wr_flit_i;
    end
  end

  // Head flit visible as soon as it lands
  assign head_flit_o = mem[rd_ptr_q[ADDR_W-1:0]];
  assign empty_o     = empty;

endmodule

`default_nettype wire

/* design/credit_counter.sv */
// ==========================================================================
// Starts full at BUF_DEPTH; credits beyond BUF_DEPTH are not guarded
// ==========================================================================
`timescale 1ns/100ps
`default_nettype none

module credit_counter #(
  parameter int BUF_DEPTH = 4
) (
  input  wire logic clk,
  input  wire logic arst_n_i,
  input  wire logic send_i,
  input  wire logic credit_i,
  output logic      has_credit_o
);

  // Wide enough to hold BUF_DEPTH itself
  localparam int CNT_W = $clog2(BUF_DEPTH + 1);

  // Free slot count downstream
  typedef logic [CNT_W-1:0] cnt_t;

  cnt_t count_q;

  // Send and credit together cancel out
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      count_q <= cnt_t'(BUF_DEPTH);
    end else if (send_i && !credit_i) begin
      count_q <= count_q - cnt_t'(1);
    end else if (credit_i && !send_i) begin
      count_q <= count_q + cnt_t'(1);
    end
  end

  // Room left in the next router
  assign has_credit_o = (count_q != '0);

endmodule

`default_nettype wire

/* design/yx_route.sv */
// ==========================================================================
// Y then X dimension order; larger Y lies north, larger X lies east
// ==========================================================================
`timescale 1ns/100ps
`default_nettype none

module yx_route (
  input  wire noc_flit_pkg::coord_t router_y_i,
  input  wire noc_flit_pkg::coord_t router_x_i,
  input  wire noc_flit_pkg::coord_t dst_y_i,
  input  wire noc_flit_pkg::coord_t dst_x_i,
  output noc_port_pkg::port_vec_t   out_port_o
);

  import noc_port_pkg::*;

  always_comb begin
    out_port_o = '0;
    // Resolve the row first
    if (dst_y_i > router_y_i) begin
      out_port_o[PORT_N] = 1'b1;
    end else if (dst_y_i < router_y_i) begin
      out_port_o[PORT_S] = 1'b1;
    // Same row so move along X
    end else if (dst_x_i > router_x_i) begin
      out_port_o[PORT_E] = 1'b1;
    end else if (dst_x_i < router_x_i) begin
      out_port_o[PORT_W] = 1'b1;
    end else begin
      // Arrived, eject to the local core
      out_port_o[PORT_L] = 1'b1;
    end
  end

endmodule

`default_nettype wire

/* design/rr_arbiter.sv */
// ==========================================================================
// Priority starts just after the last winner; L wins last after reset
// ==========================================================================
`timescale 1ns/100ps
`default_nettype none

module rr_arbiter (
  input  wire logic                    clk,
  input  wire logic                    arst_n_i,
  input  wire noc_port_pkg::port_vec_t req_i,
  input  wire logic                    en_i,
  output noc_port_pkg::port_vec_t      gnt_o
);

  import noc_port_pkg::*;

  // Last granted input
  port_idx_t last_q;
  port_idx_t win;
  port_vec_t gnt;

  // Scan the ports in order after the last winner
  always_comb begin : search
    int idx;
    gnt = '0;
    win = last_q;
    idx = 0;
    for (int i = 1; i <= NUM_PORTS; i++) begin
      idx = (int'(last_q) + i) % NUM_PORTS;
      // First requester found stops the search
      if (en_i && (gnt == '0) && req_i[idx]) begin
        gnt[idx] = 1'b1;
        win      = port_idx_t'(idx);
      end
    end
  end

  // Pointer moves only when a flit is granted
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      last_q <= PORT_L;
    end else if (gnt != '0) begin
      last_q <= win;
    end
  end

  assign gnt_o = gnt;

endmodule

`default_nettype wire

/* design/switch_allocator.sv */
// ==========================================================================
// Single-flit packets, so every grant is one complete transfer
// An output with no downstream credit grants nothing
// ==========================================================================
`timescale 1ns/100ps
`default_nettype none

module switch_allocator (
  input  wire logic                     clk,
  input  wire logic                     arst_n_i,
  input  wire noc_flit_pkg::coord_t     router_y_i,
  input  wire noc_flit_pkg::coord_t     router_x_i,
  input  wire noc_port_pkg::flit_bus_t  head_flits_i,
  input  wire noc_port_pkg::port_vec_t  empty_i,
  input  wire noc_port_pkg::port_vec_t  has_credit_i,
  output noc_port_pkg::grant_mat_t      grant_o,
  output noc_port_pkg::port_vec_t       pop_o,
  output noc_port_pkg::port_vec_t       send_o
);

  import noc_port_pkg::*;

  // Routed output of each head flit, indexed by input
  port_vec_t [NUM_PORTS-1:0] route;

  // Request masks, indexed by output
  grant_mat_t req;

  // Route computation for every input head
  for (genvar i = 0; i < NUM_PORTS; i++) begin : g_route
    yx_route i_yx_route (
      .router_y_i (router_y_i),
      .router_x_i (router_x_i),
      .dst_y_i    (head_flits_i[i].dst_y),
      .dst_x_i    (head_flits_i[i].dst_x),
      .out_port_o (route[i])
    );
  end

  // Transpose per-input routes into per-output requests
  always_comb begin
    for (int o = 0; o < NUM_PORTS; o++) begin
      for (int i = 0; i < NUM_PORTS; i++) begin
        req[o][i] = !empty_i[i] && route[i][o];
      end
    end
  end

  // One arbiter per output, held off without credit
  for (genvar o = 0; o < NUM_PORTS; o++) begin : g_arb
    rr_arbiter i_rr_arbiter (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .req_i    (req[o]),
      .en_i     (has_credit_i[o]),
      .gnt_o    (grant_o[o])
    );
  end

  // Pop per input and send per output
  always_comb begin
    pop_o = '0;
    for (int o = 0; o < NUM_PORTS; o++) begin
      send_o[o] = |grant_o[o];
      // An input requests one output, so at most one bit lands here
      pop_o = pop_o | grant_o[o];
    end
  end

endmodule

`default_nettype wire

/* design/crossbar_switch.sv */
// ==========================================================================
// Grants must be one-hot per output; data_o holds while valid_o is low
// ==========================================================================
`timescale 1ns/100ps
`default_nettype none

module crossbar_switch (
  input  wire logic                     clk,
  input  wire logic                     arst_n_i,
  input  wire noc_port_pkg::flit_bus_t  flits_i,
  input  wire noc_port_pkg::grant_mat_t grant_i,
  input  wire noc_port_pkg::port_vec_t  send_i,
  output noc_port_pkg::flit_bus_t       data_o,
  output noc_port_pkg::port_vec_t       valid_o
);

  import noc_port_pkg::*;

  // Selected flit per output
  flit_bus_t sel;

  // Grant-driven input select
  always_comb begin
    sel = '0;
    for (int o = 0; o < NUM_PORTS; o++) begin
      for (int i = 0; i < NUM_PORTS; i++) begin
        if (grant_i[o][i]) begin
          sel[o] = flits_i[i];
        end
      end
    end
  end

  // Output strobes
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o <= '0;
    end else begin
      valid_o <= send_i;
    end
  end

  // Output data, loaded only on a send
  always_ff @(posedge clk) begin
    for (int o = 0; o < NUM_PORTS; o++) begin
      if (send_i[o]) begin
        data_o[o] <= sel[o];
      end
    end
  end

endmodule

`default_nettype wire

/* design/mesh_router.sv */
// ==========================================================================
// Inner mesh node only; upstream must respect credit_o or flits are lost
// ==========================================================================
`timescale 1ns/100ps
`default_nettype none

module mesh_router #(
  parameter int BUF_DEPTH = 4
) (
  input  wire logic                    clk,
  input  wire logic                    arst_n_i,
  input  wire noc_flit_pkg::coord_t    router_y_i,
  input  wire noc_flit_pkg::coord_t    router_x_i,
  input  wire noc_port_pkg::flit_bus_t data_i,
  input  wire noc_port_pkg::port_vec_t valid_i,
  input  wire noc_port_pkg::port_vec_t credit_i,
  output noc_port_pkg::flit_bus_t      data_o,
  output noc_port_pkg::port_vec_t      valid_o,
  output noc_port_pkg::port_vec_t      credit_o
);

  import noc_port_pkg::*;

  // FIFO heads
  flit_bus_t  head_flits;
  port_vec_t  empty;

  // Downstream space per output
  port_vec_t  has_credit;

  // Allocator decisions
  port_vec_t  pop;
  port_vec_t  send;
  grant_mat_t grant;

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
    // Input side of port p
    input_buffer #(
      .BUF_DEPTH (BUF_DEPTH)
    ) i_input_buffer (
      .clk         (clk),
      .arst_n_i    (arst_n_i),
      .wr_i        (valid_i[p]),
      .rd_i        (pop[p]),
      .wr_flit_i   (data_i[p]),
      .head_flit_o (head_flits[p]),
      .empty_o     (empty[p])
    );

    // Output side of port p
    credit_counter #(
      .BUF_DEPTH (BUF_DEPTH)
    ) i_credit_counter (
      .clk          (clk),
      .arst_n_i     (arst_n_i),
      .send_i       (send[p]),
      .credit_i     (credit_i[p]),
      .has_credit_o (has_credit[p])
    );
  end

  switch_allocator i_switch_allocator (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .router_y_i   (router_y_i),
    .router_x_i   (router_x_i),
    .head_flits_i (head_flits),
    .empty_i      (empty),
    .has_credit_i (has_credit),
    .grant_o      (grant),
    .pop_o        (pop),
    .send_o       (send)
  );

  crossbar_switch i_crossbar_switch (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .flits_i  (head_flits),
    .grant_i  (grant),
    .send_i   (send),
    .data_o   (data_o),
    .valid_o  (valid_o)
  );

  // A popped slot is returned upstream at once
  assign credit_o = pop;

endmodule

`default_nettype wire

/* sim/tb_mesh_router.sv */
// ==========================================================================
// Router sits at (5,5) with BUF_DEPTH 4; payload bits 7:5 carry the source
// ==========================================================================
`timescale 1ns/100ps
`default_nettype none

module tb_mesh_router;

  import noc_flit_pkg::*;
  import noc_port_pkg::*;

  localparam int     BUF_DEPTH  = 4;
  localparam int     CLK_PERIOD = 20;
  localparam coord_t ROUTER_Y   = 4'd5;
  localparam coord_t ROUTER_X   = 4'd5;
  localparam int     N_RAND     = 200;

  // Cycle budget per test
  localparam int RESET_CYCLES = 2;
  localparam int IDLE_CYCLES  = 10;
  localparam int BURST_CYCLES = NUM_PORTS + 4;
  localparam int TOTAL_CYCLES = RESET_CYCLES + IDLE_CYCLES + 4 * NUM_PORTS * BURST_CYCLES +
                                40 + 2 * N_RAND;
  localparam int WATCHDOG_NS  = (TOTAL_CYCLES + 200) * CLK_PERIOD;

  logic      clk;
  logic      arst_n_i;
  coord_t    router_y;
  coord_t    router_x;
  flit_bus_t data_i;
  port_vec_t valid_i;
  port_vec_t credit_i;
  flit_bus_t data_o;
  port_vec_t valid_o;
  port_vec_t credit_o;

  // Reference model state
  port_idx_t last_w [NUM_PORTS];
  int        cred [NUM_PORTS];
  flit_t     pending [$];
  int        seed = 74945;

  mesh_router #(
    .BUF_DEPTH (BUF_DEPTH)
  ) i_mesh_router (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .router_y_i (router_y),
    .router_x_i (router_x),
    .data_i     (data_i),
    .valid_i    (valid_i),
    .credit_i   (credit_i),
    .data_o     (data_o),
    .valid_o    (valid_o),
    .credit_o   (credit_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic stop_run();
    $display("*** FAILED ***");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic compare_flit(input flit_t act, input flit_t exp, input string what);
    if (act !== exp) begin
      $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, what, act, exp);
      stop_run();
    end
  endtask

  task automatic compare_vec(input port_vec_t act, input port_vec_t exp, input string what);
    if (act !== exp) begin
      $display("CHECK FAILED at %0t ns: %s got %b expected %b", $time, what, act, exp);
      stop_run();
    end
  endtask

  // Outputs settle shortly after the rising edge
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  function automatic port_vec_t one_hot(input port_idx_t p);
    port_vec_t v;
    v    = '0;
    v[p] = 1'b1;
    return v;
  endfunction

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // Y first, then X; larger coordinate lies north or east
  function automatic port_idx_t ref_route(input flit_t f);
    if (f.dst_y > ROUTER_Y) return PORT_N;
    if (f.dst_y < ROUTER_Y) return PORT_S;
    if (f.dst_x > ROUTER_X) return PORT_E;
    if (f.dst_x < ROUTER_X) return PORT_W;
    return PORT_L;
  endfunction

  // Random flit aimed at output o
  function automatic flit_t make_flit(input port_idx_t o, input port_idx_t src);
    flit_t f;
    f.dst_y   = ROUTER_Y;
    f.dst_x   = ROUTER_X;
    f.payload = {src, 5'(rand_below(32))};
    case (o)
      PORT_N: begin
        f.dst_y = coord_t'(int'(ROUTER_Y) + 1 + rand_below(15 - int'(ROUTER_Y)));
        f.dst_x = coord_t'(rand_below(16));
      end
      PORT_S: begin
        f.dst_y = coord_t'(rand_below(int'(ROUTER_Y)));
        f.dst_x = coord_t'(rand_below(16));
      end
      PORT_E: f.dst_x = coord_t'(int'(ROUTER_X) + 1 + rand_below(15 - int'(ROUTER_X)));
      PORT_W: f.dst_x = coord_t'(rand_below(int'(ROUTER_X)));
      default: ;
    endcase
    return f;
  endfunction

  // Inputs in mask all aim at output o in one cycle
  task automatic send_burst(input port_idx_t o, input port_vec_t mask);
    flit_t     f [NUM_PORTS];
    port_idx_t order [$];
    port_vec_t exp_credit;
    int        idx;
    // Expected winners walk on from the last one
    for (int k = 1; k <= NUM_PORTS; k++) begin
      idx = (int'(last_w[o]) + k) % NUM_PORTS;
      if (mask[idx]) order.push_back(port_idx_t'(idx));
    end
    last_w[o] = order[order.size() - 1];
    @(negedge clk);
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (mask[p]) begin
        f[p]      = make_flit(o, port_idx_t'(p));
        data_i[p] = f[p];
      end
    end
    valid_i = mask;
    tick();
    compare_vec(valid_o, '0, "valid_o before first grant");
    compare_vec(credit_o, one_hot(order[0]), "credit_o on first pop");
    @(negedge clk);
    valid_i = '0;
    for (int j = 0; j < order.size(); j++) begin
      tick();
      exp_credit = (j + 1 < order.size()) ? one_hot(order[j + 1]) : '0;
      compare_vec(valid_o, one_hot(ref_route(f[order[j]])), $sformatf("valid_o slot %0d", j));
      compare_flit(data_o[o], f[order[j]], $sformatf("data_o slot %0d", j));
      compare_vec(credit_o, exp_credit, $sformatf("credit_o slot %0d", j));
      // Downstream frees the slot right away
      @(negedge clk);
      credit_i = one_hot(o);
    end
    tick();
    compare_vec(valid_o, '0, "valid_o after burst");
    @(negedge clk);
    credit_i = '0;
  endtask

  task automatic return_credits(input port_idx_t o, input int n);
    for (int c = 0; c < n; c++) begin
      @(negedge clk);
      credit_i = one_hot(o);
      tick();
      cred[o]++;
    end
    @(negedge clk);
    credit_i = '0;
  endtask

  task automatic expect_idle();
    for (int c = 0; c < IDLE_CYCLES; c++) begin
      tick();
      compare_vec(valid_o, '0, "valid_o while idle");
      compare_vec(credit_o, '0, "credit_o while idle");
    end
  endtask

  // Every input used once, every output reached once
  task automatic route_each_output();
    for (int o = 0; o < NUM_PORTS; o++) begin
      send_burst(port_idx_t'(o), one_hot(port_idx_t'((o + 3) % NUM_PORTS)));
    end
  endtask

  // Subset without the last winner moves the pointer
  task automatic round_robin_contention();
    port_vec_t subset;
    for (int o = 0; o < NUM_PORTS; o++) begin
      send_burst(port_idx_t'(o), '1);
      subset = port_vec_t'(rand_below(31) + 1) & ~one_hot(last_w[o]);
      if (subset == '0) begin
        subset = ~one_hot(last_w[o]);
      end
      send_burst(port_idx_t'(o), subset);
      send_burst(port_idx_t'(o), '1);
    end
  endtask

  task automatic credit_back_pressure();
    flit_t f [6];
    logic  popped;
    popped = 1'b0;
    for (int i = 0; i < 6; i++) f[i] = make_flit(PORT_W, PORT_L);
    // One flit per cycle from L with no credit returns
    for (int i = 0; i < 6; i++) begin
      @(negedge clk);
      data_i[PORT_L] = f[i];
      valid_i        = one_hot(PORT_L);
      tick();
      if (popped) begin
        compare_vec(valid_o, one_hot(PORT_W), $sformatf("valid_o stall flit %0d", i - 1));
        compare_flit(data_o[PORT_W], f[i - 1], $sformatf("data_o stall flit %0d", i - 1));
      end else begin
        compare_vec(valid_o, '0, "valid_o while out of credit");
      end
      popped = (cred[PORT_W] > 0);
      compare_vec(credit_o, popped ? one_hot(PORT_L) : '0, "credit_o under back-pressure");
      if (popped) begin
        cred[PORT_W]--;
        last_w[PORT_W] = PORT_L;
      end
    end
    @(negedge clk);
    valid_i = '0;
    expect_idle();
    // Each credit pulse releases one waiting flit
    for (int r = 0; r < 2; r++) begin
      @(negedge clk);
      credit_i = one_hot(PORT_W);
      tick();
      compare_vec(credit_o, one_hot(PORT_L), "credit_o on release");
      compare_vec(valid_o, '0, "valid_o before release");
      @(negedge clk);
      credit_i = '0;
      tick();
      compare_vec(valid_o, one_hot(PORT_W), "valid_o on release");
      compare_flit(data_o[PORT_W], f[4 + r], "data_o on release");
      compare_vec(credit_o, '0, "credit_o after release");
    end
    return_credits(PORT_W, BUF_DEPTH);
  endtask

  // First pending flit with the same source and route must match
  task automatic match_flit(input flit_t got_f, input port_idx_t o);
    int hit;
    hit = -1;
    for (int i = 0; i < pending.size(); i++) begin
      if (hit < 0 && pending[i].payload[7:5] == got_f.payload[7:5] && ref_route(pending[i]) == o)
        hit = i;
    end
    if (hit < 0) begin
      $display("Scoreboard error: output %0d delivered flit %h that was not expected", o, got_f);
      stop_run();
    end else begin
      compare_flit(got_f, pending[hit], $sformatf("flit order on output %0d", o));
      pending.delete(hit);
    end
  endtask

  task automatic random_traffic();
    int        injected;
    int        up_cred [NUM_PORTS];
    port_vec_t freed;
    port_vec_t got;
    port_vec_t inject;
    flit_t     f;
    injected = 0;
    freed    = '0;
    got      = '0;
    for (int p = 0; p < NUM_PORTS; p++) up_cred[p] = BUF_DEPTH;
    while (injected < N_RAND || pending.size() > 0) begin
      @(negedge clk);
      inject = '0;
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (injected < N_RAND && up_cred[p] > 0 && rand_below(2) == 1) begin
          f.dst_y   = coord_t'(rand_below(16));
          f.dst_x   = coord_t'(rand_below(16));
          f.payload = {port_idx_t'(p), 5'(rand_below(32))};
          data_i[p] = f;
          inject[p] = 1'b1;
          up_cred[p]--;
          injected++;
          pending.push_back(f);
        end
      end
      valid_i  = inject;
      credit_i = got;
      tick();
      // Upstream may reuse a slot one cycle after its credit
      for (int p = 0; p < NUM_PORTS; p++) if (freed[p]) up_cred[p]++;
      freed = credit_o;
      got   = valid_o;
      for (int o = 0; o < NUM_PORTS; o++) if (valid_o[o]) match_flit(data_o[o], port_idx_t'(o));
    end
    @(negedge clk);
    credit_i = got;
    tick();
    compare_vec(valid_o, '0, "valid_o after random traffic");
    @(negedge clk);
    credit_i = '0;
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    stop_run();
  end

  initial begin
    arst_n_i = 1'b0;
    router_y = ROUTER_Y;
    router_x = ROUTER_X;
    data_i   = '0;
    valid_i  = '0;
    credit_i = '0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      last_w[p] = PORT_L;
      cred[p]   = BUF_DEPTH;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    arst_n_i = 1'b1;
    expect_idle();
    route_each_output();
    round_robin_contention();
    credit_back_pressure();
    random_traffic();
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
design/noc_flit_pkg.sv
design/noc_port_pkg.sv
design/input_buffer.sv
design/credit_counter.sv
design/yx_route.sv
design/rr_arbiter.sv
design/switch_allocator.sv
design/crossbar_switch.sv
design/mesh_router.sv
sim/tb_mesh_router.sv

/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing -j 0
TOP      := tb_mesh_router
FILELIST := compile.f
OBJ_DIR  := obj_dir

.PHONY: sim clean

# Build and run; a $fatal in the testbench gives a non-zero exit status
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
